// ==== dmem_config.svh ====
`ifndef DMEM_CONFIG_SVH
`define DMEM_CONFIG_SVH

// Scratchpad region, base aligned to the region size
`define DMEM_SCRATCH_BASE 32'h0001_0000

// Scratchpad depth in 32-bit words, power of two
`define DMEM_SCRATCH_WORDS 256

// AXI ID port width
`define DMEM_AXI_ID_W 4

`endif

// ==== axi_pkg.sv ====
package axi_pkg;

	localparam logic [1:0] BURST_INCR = 2'b01;
	localparam logic [2:0] SIZE_4B    = 3'b010;

	// Master side channels, IDs travel separately
	typedef struct packed {
		// Read address
		logic [31:0] araddr;
		logic [3:0]  arlen;
		logic [2:0]  arsize;
		logic [1:0]  arburst;
		logic        arvalid;
		// Write address
		logic [31:0] awaddr;
		logic [3:0]  awlen;
		logic [2:0]  awsize;
		logic [1:0]  awburst;
		logic        awvalid;
		// Write data
		logic [31:0] wdata;
		logic [3:0]  wstrb;
		logic        wlast;
		logic        wvalid;
		// Response readies
		logic        rready;
		logic        bready;
	} axi_req_t;

	// Slave side, no error responses
	typedef struct packed {
		logic        arready;
		logic        awready;
		logic        wready;
		logic [31:0] rdata;
		logic        rvalid;
		logic        bvalid;
	} axi_resp_t;

endpackage

// ==== cpu_bus_pkg.sv ====
package cpu_bus_pkg;

	typedef logic [31:0] word_t;

	// CPU data bus request, held while stall is high
	typedef struct packed {
		logic        read;
		logic        write;
		logic [31:0] address;
		logic [3:0]  byteenable;
		word_t       wrdata;
	} dbus_req_t;

	typedef struct packed {
		logic  stall;
		word_t rddata;    // Valid in first unstalled cycle after a read
	} dbus_resp_t;

endpackage

// ==== dcache_pass.sv ====
`timescale 1ns/100ps
`include "dmem_config.svh"

module dcache_pass (
	input  logic                         clk,
	input  logic                         rst,
	input  cpu_bus_pkg::dbus_req_t       dbus_req,
	output cpu_bus_pkg::dbus_resp_t      dbus_resp,
	output axi_pkg::axi_req_t            axi_req,
	output logic [`DMEM_AXI_ID_W-1:0]    axi_req_arid,
	output logic [`DMEM_AXI_ID_W-1:0]    axi_req_awid,
	output logic [`DMEM_AXI_ID_W-1:0]    axi_req_wid,
	input  axi_pkg::axi_resp_t           axi_resp,
	input  logic [`DMEM_AXI_ID_W-1:0]    axi_resp_rid,
	input  logic [`DMEM_AXI_ID_W-1:0]    axi_resp_bid
);

typedef enum logic [2:0] {
	IDLE,
	READ_WAIT_AXI,
	WRITE_WAIT_AXI,
	READ,
	WRITE,
	WAIT_BVALID,
	WAIT_BVALID_RD,
	WAIT_BVALID_WR
} state_t;

state_t state, state_d;

cpu_bus_pkg::dbus_req_t pipe;

// Single outstanding transaction, responses never reordered
assign axi_req_arid = '0;
assign axi_req_awid = '0;
assign axi_req_wid  = '0;

// Posted write: CPU runs on while only the B response is pending
assign dbus_resp.stall  = (state_d != IDLE) && (state_d != WAIT_BVALID);
assign dbus_resp.rddata = axi_resp.rdata;

always_comb begin
	state_d = state;
	case (state)
		IDLE: begin
			// Valid already driven here, so a ready now completes the address phase
			if (pipe.read) begin
				state_d = axi_resp.arready ? READ : READ_WAIT_AXI;
			end else if (pipe.write) begin
				state_d = axi_resp.awready ? WRITE : WRITE_WAIT_AXI;
			end
		end
		READ_WAIT_AXI: begin
			if (axi_resp.arready)
				state_d = READ;
		end
		WRITE_WAIT_AXI: begin
			if (axi_resp.awready)
				state_d = WRITE;
		end
		READ: begin
			if (axi_resp.rvalid)
				state_d = IDLE;
		end
		WRITE: begin
			if (axi_resp.wready)
				state_d = WAIT_BVALID;
		end
		WAIT_BVALID: begin
			if (axi_resp.bvalid) begin
				if (pipe.read)
					state_d = READ_WAIT_AXI;
				else if (pipe.write)
					state_d = WRITE_WAIT_AXI;
				else
					state_d = IDLE;
			end else if (pipe.read) begin
				state_d = WAIT_BVALID_RD;    // Keep the read behind the write
			end else if (pipe.write) begin
				state_d = WAIT_BVALID_WR;
			end
		end
		WAIT_BVALID_RD: begin
			if (axi_resp.bvalid)
				state_d = READ_WAIT_AXI;
		end
		WAIT_BVALID_WR: begin
			if (axi_resp.bvalid)
				state_d = WRITE_WAIT_AXI;
		end
		default: state_d = IDLE;
	endcase
end

always_comb begin
	axi_req = '0;

	// One beat INCR bursts only
	axi_req.araddr  = {pipe.address[31:2], 2'b00};
	axi_req.arlen   = 4'd0;
	axi_req.arsize  = axi_pkg::SIZE_4B;
	axi_req.arburst = axi_pkg::BURST_INCR;
	axi_req.awaddr  = {pipe.address[31:2], 2'b00};
	axi_req.awlen   = 4'd0;
	axi_req.awsize  = axi_pkg::SIZE_4B;
	axi_req.awburst = axi_pkg::BURST_INCR;
	axi_req.wdata   = pipe.wrdata;
	axi_req.wstrb   = pipe.byteenable;
	axi_req.wlast   = 1'b1;
	axi_req.bready  = 1'b1;

	case (state)
		IDLE: begin
			axi_req.arvalid = pipe.read;
			axi_req.awvalid = pipe.write & ~pipe.read;
		end
		READ_WAIT_AXI:  axi_req.arvalid = 1'b1;
		WRITE_WAIT_AXI: axi_req.awvalid = 1'b1;
		READ:           axi_req.rready  = 1'b1;
		WRITE:          axi_req.wvalid  = 1'b1;
		default: ;
	endcase
end

always_ff @(posedge clk) begin
	if (rst) begin
		state <= IDLE;
	end else begin
		state <= state_d;
	end
end

// Request pipe, payload needs no reset
always_ff @(posedge clk) begin
	if (rst) begin
		pipe.read  <= 1'b0;
		pipe.write <= 1'b0;
	end else if (~dbus_resp.stall) begin
		pipe <= dbus_req;
	end
end

endmodule

// ==== dscratch.sv ====
`timescale 1ns/100ps
`include "dmem_config.svh"

module dscratch (
	input  logic                   clk,
	input  cpu_bus_pkg::dbus_req_t req,
	output cpu_bus_pkg::word_t     rddata
);

localparam int IDX_W = $clog2(`DMEM_SCRATCH_WORDS);

cpu_bus_pkg::word_t mem [`DMEM_SCRATCH_WORDS];

logic [IDX_W-1:0] idx;

assign idx = req.address[IDX_W+1:2];    // Word index inside the region

always_ff @(posedge clk) begin
	if (req.write) begin
		for (int b = 0; b < 4; b++) begin
			if (req.byteenable[b])
				mem[idx][8*b +: 8] <= req.wrdata[8*b +: 8];
		end
	end
	if (req.read)
		rddata <= mem[idx];    // Held until the next read
end

endmodule

// ==== dbus_router.sv ====
`timescale 1ns/100ps
`include "dmem_config.svh"

module dbus_router (
	input  logic                    clk,
	input  logic                    rst,
	input  cpu_bus_pkg::dbus_req_t  cpu_req,
	output cpu_bus_pkg::dbus_resp_t cpu_resp,
	output cpu_bus_pkg::dbus_req_t  scratch_req,
	input  cpu_bus_pkg::word_t      scratch_rddata,
	output cpu_bus_pkg::dbus_req_t  pass_req,
	input  cpu_bus_pkg::dbus_resp_t pass_resp
);

localparam logic [31:0] SCRATCH_BASE  = `DMEM_SCRATCH_BASE;
localparam logic [31:0] SCRATCH_BYTES = 32'(`DMEM_SCRATCH_WORDS) * 32'd4;
localparam logic [31:0] SCRATCH_MASK  = ~(SCRATCH_BYTES - 32'd1);

logic in_scratch;
logic stall;
logic rd_from_scratch;    // Source of the last accepted read

assign in_scratch = (cpu_req.address & SCRATCH_MASK) == SCRATCH_BASE;
assign stall      = pass_resp.stall;

always_comb begin
	scratch_req = cpu_req;
	pass_req    = cpu_req;

	// Scratchpad must not act on a request the CPU is still holding
	scratch_req.read  = cpu_req.read & in_scratch & ~stall;
	scratch_req.write = cpu_req.write & in_scratch & ~stall;

	// Pass block only samples its input while unstalled
	pass_req.read  = cpu_req.read & ~in_scratch;
	pass_req.write = cpu_req.write & ~in_scratch;
end

always_ff @(posedge clk) begin
	if (rst) begin
		rd_from_scratch <= 1'b0;
	end else if (cpu_req.read & ~stall) begin
		rd_from_scratch <= in_scratch;
	end
end

assign cpu_resp.stall  = stall;
assign cpu_resp.rddata = rd_from_scratch ? scratch_rddata : pass_resp.rddata;

endmodule

// ==== dmem_top.sv ====
`timescale 1ns/100ps
`include "dmem_config.svh"

module dmem_top (
	input  logic                      clk,
	input  logic                      rst,
	input  cpu_bus_pkg::dbus_req_t    dbus_req,
	output cpu_bus_pkg::dbus_resp_t   dbus_resp,
	output axi_pkg::axi_req_t         axi_req,
	output logic [`DMEM_AXI_ID_W-1:0] axi_req_arid,
	output logic [`DMEM_AXI_ID_W-1:0] axi_req_awid,
	output logic [`DMEM_AXI_ID_W-1:0] axi_req_wid,
	input  axi_pkg::axi_resp_t        axi_resp,
	input  logic [`DMEM_AXI_ID_W-1:0] axi_resp_rid,
	input  logic [`DMEM_AXI_ID_W-1:0] axi_resp_bid
);

cpu_bus_pkg::dbus_req_t  scratch_req;
cpu_bus_pkg::word_t      scratch_rddata;
cpu_bus_pkg::dbus_req_t  pass_req;
cpu_bus_pkg::dbus_resp_t pass_resp;

dbus_router router0 (
	.clk            (clk),
	.rst            (rst),
	.cpu_req        (dbus_req),
	.cpu_resp       (dbus_resp),
	.scratch_req    (scratch_req),
	.scratch_rddata (scratch_rddata),
	.pass_req       (pass_req),
	.pass_resp      (pass_resp)
);

dscratch scratch0 (
	.clk    (clk),
	.req    (scratch_req),
	.rddata (scratch_rddata)
);

// Everything outside the scratchpad goes out uncached
dcache_pass pass0 (
	.clk          (clk),
	.rst          (rst),
	.dbus_req     (pass_req),
	.dbus_resp    (pass_resp),
	.axi_req      (axi_req),
	.axi_req_arid (axi_req_arid),
	.axi_req_awid (axi_req_awid),
	.axi_req_wid  (axi_req_wid),
	.axi_resp     (axi_resp),
	.axi_resp_rid (axi_resp_rid),
	.axi_resp_bid (axi_resp_bid)
);

endmodule

// ==== tb_clkgen.sv ====
`timescale 1ns/100ps

module tb_clkgen (
	output logic clk,
	output logic rst
);

localparam real HALF_PERIOD = 4.0;    // 8 ns clock

initial begin
	clk = 1'b0;
	forever #(HALF_PERIOD) clk = ~clk;
end

initial begin
	rst = 1'b1;
	repeat (3) @(posedge clk);
	@(negedge clk);    // Release between edges
	rst = 1'b0;
end

endmodule

// ==== tb_dmem.sv ====
`timescale 1ns/100ps
`include "dmem_config.svh"

module tb_dmem;

localparam logic [31:0] UNC_BASE = 32'h0002_0000;    // Small uncached window
localparam int TIMEOUT = 200;

logic clk;
logic rst;
cpu_bus_pkg::dbus_req_t dbus_req;
cpu_bus_pkg::dbus_resp_t dbus_resp;
axi_pkg::axi_req_t axi_req;
axi_pkg::axi_resp_t axi_resp;
logic [`DMEM_AXI_ID_W-1:0] arid, awid, wid, rid, bid;

logic [31:0] lfsr;
cpu_bus_pkg::word_t ref_mem [64];    // Scratch words 0..31, uncached 32..63
cpu_bus_pkg::word_t slave_mem [32];
logic slave_written [32];
cpu_bus_pkg::dbus_req_t unc_q [$];
cpu_bus_pkg::dbus_req_t next_req;
cpu_bus_pkg::dbus_req_t w_exp;

logic accepted;
logic rd_pending;
logic rd_scratch;
cpu_bus_pkg::word_t rd_exp;
logic scratch_only;

int ar_cnt, aw_cnt, w_cnt, r_cnt, b_cnt;
logic r_pending, b_pending, b_hold;
logic [31:0] r_addr, aw_addr;
int ar_seen, aw_seen, w_seen, unc_rd_issued, unc_wr_issued;

tb_clkgen clkgen0 (.clk(clk), .rst(rst));

dmem_top dut0 (
	.clk          (clk),
	.rst          (rst),
	.dbus_req     (dbus_req),
	.dbus_resp    (dbus_resp),
	.axi_req      (axi_req),
	.axi_req_arid (arid),
	.axi_req_awid (awid),
	.axi_req_wid  (wid),
	.axi_resp     (axi_resp),
	.axi_resp_rid (rid),
	.axi_resp_bid (bid)
);

function automatic logic lfsr_bit();
	logic b;
	b = lfsr[0];
	lfsr = lfsr >> 1;
	if (b)
		lfsr = lfsr ^ 32'h8020_0003;
	return b;
endfunction

function automatic logic [31:0] rbits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++)
		v = {v[30:0], lfsr_bit()};
	return v;
endfunction

function automatic int rand_delay();
	return int'(rbits(3)) % 6;    // 0 to 5 cycles
endfunction

function automatic cpu_bus_pkg::word_t fill_word(input logic [31:0] addr);
	return {addr[15:0], addr[31:16]} ^ 32'h5A5A_C3C3;
endfunction

function automatic logic is_scratch(input logic [31:0] addr);
	return (addr - `DMEM_SCRATCH_BASE) < (`DMEM_SCRATCH_WORDS * 4);
endfunction

function automatic int model_idx(input logic [31:0] addr);
	return is_scratch(addr) ? int'(addr[6:2]) : 32 + int'(addr[6:2]);
endfunction

function automatic cpu_bus_pkg::word_t merge_bytes(input cpu_bus_pkg::word_t old,
		input cpu_bus_pkg::word_t data, input logic [3:0] be);
	cpu_bus_pkg::word_t v;
	v = old;
	for (int b = 0; b < 4; b++)
		if (be[b])
			v[8*b +: 8] = data[8*b +: 8];
	return v;
endfunction

function automatic cpu_bus_pkg::word_t slave_read(input logic [31:0] addr);
	if (slave_written[addr[6:2]])
		return slave_mem[addr[6:2]];
	return fill_word(addr);
endfunction

function automatic cpu_bus_pkg::dbus_req_t make_req(input logic allow_unc);
	cpu_bus_pkg::dbus_req_t r;
	logic wr;
	logic unc;
	logic [4:0] word;
	r = '0;
	wr = rbits(1);
	unc = allow_unc ? rbits(1) : 1'b0;
	word = rbits(5);
	r.address = (unc ? UNC_BASE : `DMEM_SCRATCH_BASE) + {word, 2'b00};
	r.read = ~wr;
	r.write = wr;
	r.byteenable = wr ? rbits(4) : 4'hF;
	r.wrdata = wr ? rbits(32) : '0;
	return r;
endfunction

task abort_run();
	$display("Test failed");
	$fatal(1);
endtask

task check_word(input string name, input cpu_bus_pkg::word_t exp, input cpu_bus_pkg::word_t act);
	if (act !== exp) begin
		$display("ERR %s expected %h actual %h", name, exp, act);
		abort_run();
	end
endtask

task check_axi_req(input string name, input axi_pkg::axi_req_t exp, input axi_pkg::axi_req_t act);
	if (act !== exp) begin
		$display("ERR %s expected %h actual %h", name, exp, act);
		abort_run();
	end
endtask

task check_flag(input string name, input logic exp, input logic act);
	if (act !== exp) begin
		$display("ERR %s expected %b actual %b", name, exp, act);
		abort_run();
	end
endtask

task check_id(input string name, input logic [`DMEM_AXI_ID_W-1:0] exp,
		input logic [`DMEM_AXI_ID_W-1:0] act);
	if (act !== exp) begin
		$display("ERR %s expected %h actual %h", name, exp, act);
		abort_run();
	end
endtask

task check_count(input string name, input int exp, input int act);
	if (act != exp) begin
		$display("ERR %s expected %0d actual %0d", name, exp, act);
		abort_run();
	end
endtask

// Slave outputs for the coming cycle
task drive_slave();
	axi_resp.arready = (ar_cnt == 0);
	if (ar_cnt > 0)
		ar_cnt--;
	axi_resp.awready = (aw_cnt == 0);
	if (aw_cnt > 0)
		aw_cnt--;
	axi_resp.wready = (w_cnt == 0);
	if (w_cnt > 0)
		w_cnt--;
	axi_resp.rvalid = 1'b0;
	axi_resp.rdata = '0;
	if (r_pending) begin
		if (r_cnt == 0) begin
			axi_resp.rvalid = 1'b1;
			axi_resp.rdata = slave_read(r_addr);
		end else begin
			r_cnt--;
		end
	end
	axi_resp.bvalid = 1'b0;
	if (b_pending) begin
		if (b_cnt == 0)
			axi_resp.bvalid = 1'b1;
		else
			b_cnt--;
	end
endtask

// Looks at what the next rising edge will see
task sample();
	cpu_bus_pkg::dbus_req_t q;
	axi_pkg::axi_req_t exp;
	int idx;
	accepted = 1'b0;
	if (scratch_only) begin
		check_flag("scratch_stall", 1'b0, dbus_resp.stall);
		if (axi_req.arvalid || axi_req.awvalid || axi_req.wvalid) begin
			$display("An AXI valid rose during scratchpad-only traffic");
			abort_run();
		end
	end
	if (b_pending && (axi_req.arvalid || axi_req.awvalid)) begin
		$display("A new AXI address phase started before the write response");
		abort_run();
	end
	if (rd_pending) begin
		if (!dbus_resp.stall) begin
			check_word(rd_scratch ? "scratch_read" : "uncached_read", rd_exp, dbus_resp.rddata);
			rd_pending = 1'b0;
		end else if (rd_scratch) begin
			$display("Stall rose while scratchpad read data was due");
			abort_run();
		end
	end
	if (axi_req.arvalid && axi_resp.arready) begin
		if (unc_q.size() == 0 || !unc_q[0].read) begin
			$display("AR handshake without a matching uncached read");
			abort_run();
		end
		q = unc_q.pop_front();
		exp = axi_req;
		exp.araddr = q.address;
		exp.arlen = 4'd0;
		exp.arsize = 3'd2;
		exp.arburst = 2'b01;
		check_axi_req("ar_phase", exp, axi_req);
		ar_seen++;
		r_pending = 1'b1;
		r_addr = q.address;
		r_cnt = rand_delay();
		ar_cnt = rand_delay();
	end
	if (axi_req.awvalid && axi_resp.awready) begin
		if (unc_q.size() == 0 || !unc_q[0].write) begin
			$display("AW handshake without a matching uncached write");
			abort_run();
		end
		q = unc_q.pop_front();
		exp = axi_req;
		exp.awaddr = q.address;
		exp.awlen = 4'd0;
		exp.awsize = 3'd2;
		exp.awburst = 2'b01;
		check_axi_req("aw_phase", exp, axi_req);
		aw_seen++;
		w_exp = q;
		aw_addr = q.address;
		aw_cnt = rand_delay();
	end
	if (axi_req.wvalid && axi_resp.wready) begin
		exp = axi_req;
		exp.wdata = w_exp.wrdata;
		exp.wstrb = w_exp.byteenable;
		exp.wlast = 1'b1;
		check_axi_req("w_phase", exp, axi_req);
		slave_mem[aw_addr[6:2]] = merge_bytes(slave_read(aw_addr), axi_req.wdata,
			axi_req.wstrb);
		slave_written[aw_addr[6:2]] = 1'b1;
		w_seen++;
		b_pending = 1'b1;
		b_cnt = b_hold ? 15 : rand_delay();
		w_cnt = rand_delay();
	end
	if (axi_resp.rvalid && axi_req.rready)
		r_pending = 1'b0;
	if (axi_resp.bvalid) begin
		check_flag("bready", 1'b1, axi_req.bready);
		b_pending = 1'b0;
	end
	if ((dbus_req.read || dbus_req.write) && !dbus_resp.stall) begin
		accepted = 1'b1;
		idx = model_idx(dbus_req.address);
		if (!is_scratch(dbus_req.address)) begin
			unc_q.push_back(dbus_req);
			if (dbus_req.read)
				unc_rd_issued++;
			else
				unc_wr_issued++;
		end
		if (dbus_req.write) begin
			ref_mem[idx] = merge_bytes(ref_mem[idx], dbus_req.wrdata, dbus_req.byteenable);
		end else begin
			rd_pending = 1'b1;
			rd_scratch = is_scratch(dbus_req.address);
			rd_exp = ref_mem[idx];
		end
	end
endtask

task cycle();
	@(negedge clk);
	drive_slave();
	dbus_req = next_req;
	#2;
	sample();
endtask

task idle(input int n);
	next_req = '0;
	repeat (n) cycle();
endtask

task issue(input cpu_bus_pkg::dbus_req_t req);
	next_req = req;
	for (int t = 0; t < TIMEOUT; t++) begin
		cycle();
		if (accepted)
			break;
	end
	if (!accepted) begin
		$display("Request to address %h was never accepted", req.address);
		abort_run();
	end
	next_req = '0;
endtask

task drain();
	logic busy;
	busy = 1'b1;
	for (int t = 0; t < TIMEOUT; t++) begin
		cycle();
		busy = rd_pending | r_pending | b_pending | dbus_resp.stall;
		if (!busy)
			break;
	end
	if (busy) begin
		$display("Outstanding accesses did not complete in time");
		abort_run();
	end
endtask

initial begin
	cpu_bus_pkg::dbus_req_t r;
	dbus_req = '0;
	next_req = '0;
	axi_resp = '0;
	rid = '0;
	bid = '0;
	lfsr = 32'd99;
	{accepted, rd_pending, rd_scratch, scratch_only} = '0;
	{r_pending, b_pending, b_hold} = '0;
	{ar_cnt, aw_cnt, w_cnt, r_cnt, b_cnt} = '0;
	{ar_seen, aw_seen, w_seen, unc_rd_issued, unc_wr_issued} = '0;
	for (int i = 0; i < 32; i++) begin
		ref_mem[32 + i] = fill_word(UNC_BASE + 32'(i) * 4);
		slave_written[i] = 1'b0;
	end

	for (int t = 0; t < 20; t++) begin
		@(posedge clk);
		if (!rst)
			break;
	end
	if (rst) begin
		$display("Reset was never released");
		abort_run();
	end
	@(negedge clk);
	#2;
	check_flag("reset_stall", 1'b0, dbus_resp.stall);
	check_flag("reset_arvalid", 1'b0, axi_req.arvalid);
	check_flag("reset_awvalid", 1'b0, axi_req.awvalid);
	check_flag("reset_wvalid", 1'b0, axi_req.wvalid);
	check_flag("reset_rready", 1'b0, axi_req.rready);
	check_id("reset_arid", '0, arid);
	check_id("reset_awid", '0, awid);
	check_id("reset_wid", '0, wid);

	// Scratch RAM powers up unknown so every word gets written before any read
	scratch_only = 1'b1;
	for (int i = 0; i < 32; i++) begin
		r = '0;
		r.write = 1'b1;
		r.address = `DMEM_SCRATCH_BASE + 32'(i) * 4;
		r.byteenable = 4'hF;
		r.wrdata = rbits(32);
		issue(r);
	end
	for (int i = 0; i < 60; i++) begin
		issue(make_req(1'b0));
		idle(int'(rbits(1)));
	end
	drain();
	scratch_only = 1'b0;

	for (int i = 0; i < 200; i++) begin
		issue(make_req(1'b1));
		idle(int'(rbits(2)));
	end
	drain();

	// Slow B response behind a posted write
	b_hold = 1'b1;
	r = '0;
	r.write = 1'b1;
	r.address = UNC_BASE + 32'h14;
	r.byteenable = 4'hF;
	r.wrdata = 32'hCAFE_0123;
	issue(r);
	r.address = `DMEM_SCRATCH_BASE + 32'h1C;
	r.wrdata = 32'h0BAD_F00D;
	issue(r);
	r.write = 1'b0;
	r.read = 1'b1;
	issue(r);
	check_flag("b_withheld", 1'b1, b_pending);
	r.address = UNC_BASE + 32'h14;
	issue(r);
	b_hold = 1'b0;
	drain();

	check_count("ar_count", unc_rd_issued, ar_seen);
	check_count("aw_count", unc_wr_issued, aw_seen);
	check_count("w_count", unc_wr_issued, w_seen);

	$display("Test passed");
	$finish;
end

endmodule

// ==== sim.f ====
+incdir+.
axi_pkg.sv
cpu_bus_pkg.sv
dcache_pass.sv
dscratch.sv
dbus_router.sv
dmem_top.sv
tb_clkgen.sv
tb_dmem.sv
